//--- logic/div_cfg.svh
// widths follow RV64 and are not meant to be changed; DIV_CNT_W must be able to hold DIV_XLEN
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// data width, also the step count of a full divide
`define DIV_XLEN 64

// word forms (divw, remuw ...) use the low half, also their step count
`define DIV_WORD_LEN 32

// destination register tag, x0 to x31
`define DIV_REG_ADDR_W 5

// holds the largest step count
`define DIV_CNT_W 7

`endif

//--- logic/div_pkg.sv
// op codes are fixed at 0 to 3 because the trace file writes them as plain numbers
`include "div_cfg.svh"

package div_pkg;

	typedef logic [`DIV_XLEN-1:0] xlen_t;

	typedef logic [`DIV_REG_ADDR_W-1:0] reg_addr_t;

	// DIV and REM are signed, REM and REMU give the remainder
	typedef enum logic [1:0] {
		DIV  = 2'd0,
		DIVU = 2'd1,
		REM  = 2'd2,
		REMU = 2'd3
	} div_op_t;

	// FIX is always one cycle, RUN lasts one cycle per quotient bit
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		RUN  = 2'd1,
		FIX  = 2'd2
	} div_state_t;

endpackage

//--- logic/iteration_counter.sv
// last is only meaningful while steps are running; a step at count zero is ignored
`include "div_cfg.svh"

module iteration_counter (
	input  logic clock,
	input  logic reset,
	input  logic load,
	input  logic word,
	input  logic step,
	output logic last
);

	logic [`DIV_CNT_W-1:0] count;

	// high during the final shift-subtract step
	assign last = (count == `DIV_CNT_W'(1));

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else if (load) begin
			// one step per quotient bit
			count <= word ? `DIV_CNT_W'(`DIV_WORD_LEN) : `DIV_CNT_W'(`DIV_XLEN);
		end else if (step && (count != '0)) begin
			count <= count - 1'b1;
		end
	end

endmodule

//--- logic/div_control.sv
// one request in flight, no queue; an issue_valid seen while stall_req is high is dropped
`include "div_cfg.svh"

module div_control import div_pkg::*; (
	input  logic clock,
	input  logic reset,
	input  logic issue_valid,
	input  logic special,
	input  logic last,
	output logic accept,
	output logic step,
	output logic finish,
	output logic stall_req,
	output logic commit_valid
);

	div_state_t state;
	div_state_t state_next;

	// only IDLE takes a request, same as issue_valid with stall_req low
	assign accept = issue_valid && (state == IDLE);
	assign step = (state == RUN);
	assign finish = (state == FIX);

	// low again in the commit cycle so the next request can go in
	assign stall_req = (state != IDLE);

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				// zero divisor and overflow need no steps
				if (accept) begin
					state_next = special ? FIX : RUN;
				end
			end
			RUN: begin
				if (last) begin
					state_next = FIX;
				end
			end
			FIX: begin
				state_next = IDLE;
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			commit_valid <= 1'b0;
		end else begin
			state <= state_next;
			// result register is written at the FIX edge, pulse follows it
			commit_valid <= finish;
		end
	end

endmodule

//--- logic/div_datapath.sv
// word forms read only bits 31:0 of rs1 and rs2, and all their results are sign-extended from bit 31
`include "div_cfg.svh"

module div_datapath import div_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      accept,
	input  logic      step,
	input  logic      finish,
	input  div_op_t   issue_op,
	input  logic      issue_word,
	input  reg_addr_t issue_rd,
	input  xlen_t     rs1_data,
	input  xlen_t     rs2_data,
	output logic      special,
	output reg_addr_t commit_rd,
	output xlen_t     commit_data
);

	localparam int XLEN = `DIV_XLEN;
	localparam int WLEN = `DIV_WORD_LEN;

	// decode of the incoming request
	logic in_signed;
	xlen_t a_ext;
	xlen_t b_ext;
	logic a_neg;
	logic b_neg;
	xlen_t a_mag;
	xlen_t b_mag;
	xlen_t min_mag;
	logic div_zero;
	logic overflow;

	// captured at accept
	logic word_q;
	logic is_rem_q;
	logic quo_neg_q;
	logic rem_neg_q;
	logic zero_q;
	logic ovf_q;
	reg_addr_t rd_q;
	xlen_t dividend_q;
	xlen_t divisor_q;

	// partial remainder and quotient shift register
	xlen_t rem_q;
	xlen_t quo_q;
	logic [XLEN:0] rem_shift;
	logic [XLEN:0] diff;

	// final value
	xlen_t quo_fix;
	xlen_t rem_fix;
	xlen_t result;

	// word form keeps the low half, extended by sign or by zero
	function automatic xlen_t narrow(input xlen_t value, input logic word, input logic sign_ext);
		logic fill;
		fill = sign_ext && value[WLEN-1];
		if (word) begin
			narrow = {{(XLEN-WLEN){fill}}, value[WLEN-1:0]};
		end else begin
			narrow = value;
		end
	endfunction

	always_comb begin
		in_signed = (issue_op == DIV) || (issue_op == REM);
		a_ext = narrow(rs1_data, issue_word, in_signed);
		b_ext = narrow(rs2_data, issue_word, in_signed);
		// after narrowing, bit 63 carries the sign for both forms
		a_neg = in_signed && a_ext[XLEN-1];
		b_neg = in_signed && b_ext[XLEN-1];
		a_mag = a_neg ? -a_ext : a_ext;
		b_mag = b_neg ? -b_ext : b_ext;
		// magnitude of the most negative dividend
		min_mag = issue_word ? (xlen_t'(1) << (WLEN - 1)) : (xlen_t'(1) << (XLEN - 1));
		div_zero = (b_ext == '0);
		overflow = a_neg && (a_mag == min_mag) && (b_ext == '1);
	end

	// decided on the incoming operands so the control can skip RUN
	assign special = div_zero || overflow;

	// one restoring step, remainder stays below the divisor so 65 bits suffice
	assign rem_shift = {rem_q, quo_q[XLEN-1]};
	assign diff = rem_shift - {1'b0, divisor_q};

	always_ff @(posedge clock) begin
		if (accept) begin
			word_q <= issue_word;
			is_rem_q <= (issue_op == REM) || (issue_op == REMU);
			quo_neg_q <= a_neg ^ b_neg;
			// remainder follows the dividend
			rem_neg_q <= a_neg;
			zero_q <= div_zero;
			ovf_q <= overflow;
			rd_q <= issue_rd;
			dividend_q <= a_ext;
			divisor_q <= b_mag;
			rem_q <= '0;
			// word dividend starts at the top so its 32 steps see every bit
			quo_q <= issue_word ? (a_mag << (XLEN - WLEN)) : a_mag;
		end else if (step) begin
			if (!diff[XLEN]) begin
				rem_q <= diff[XLEN-1:0];
			end else begin
				rem_q <= rem_shift[XLEN-1:0];
			end
			quo_q <= {quo_q[XLEN-2:0], !diff[XLEN]};
		end
	end

	always_comb begin
		quo_fix = quo_neg_q ? -quo_q : quo_q;
		rem_fix = rem_neg_q ? -rem_q : rem_q;
		if (zero_q) begin
			// x/0 gives all ones, x%0 gives x
			result = is_rem_q ? dividend_q : '1;
		end else if (ovf_q) begin
			// min/-1 gives min, remainder zero
			result = is_rem_q ? '0 : dividend_q;
		end else begin
			result = is_rem_q ? rem_fix : quo_fix;
		end
		// also applies to divuw and remuw
		if (word_q) begin
			result = narrow(result, 1'b1, 1'b1);
		end
	end

	// holds until the next commit
	always_ff @(posedge clock) begin
		if (reset) begin
			commit_data <= '0;
			commit_rd <= '0;
		end else if (finish) begin
			commit_data <= result;
			commit_rd <= rd_q;
		end
	end

endmodule

//--- logic/div_unit_top.sv
// source must hold issue_valid until stall_req is low; one commit pulse per accepted request
`include "div_cfg.svh"

module div_unit_top import div_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      issue_valid,
	input  div_op_t   issue_op,
	input  logic      issue_word,
	input  reg_addr_t issue_rd,
	input  xlen_t     rs1_data,
	input  xlen_t     rs2_data,
	output logic      stall_req,
	output logic      commit_valid,
	output reg_addr_t commit_rd,
	output xlen_t     commit_data
);

	logic accept;
	logic step;
	logic finish;
	logic special;
	logic last;

	div_control u_control (
		.clock        (clock),
		.reset        (reset),
		.issue_valid  (issue_valid),
		.special      (special),
		.last         (last),
		.accept       (accept),
		.step         (step),
		.finish       (finish),
		.stall_req    (stall_req),
		.commit_valid (commit_valid)
	);

	// step count is picked at accept time from the word flag
	iteration_counter u_counter (
		.clock (clock),
		.reset (reset),
		.load  (accept),
		.word  (issue_word),
		.step  (step),
		.last  (last)
	);

	div_datapath u_datapath (
		.clock       (clock),
		.reset       (reset),
		.accept      (accept),
		.step        (step),
		.finish      (finish),
		.issue_op    (issue_op),
		.issue_word  (issue_word),
		.issue_rd    (issue_rd),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.special     (special),
		.commit_rd   (commit_rd),
		.commit_data (commit_data)
	);

endmodule

//--- test/clock_gen.sv
// free-running clock of period 40 from time 0; reset is released on the fourth rising edge
module clock_gen (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever begin
			#20 clock = ~clock;
		end
	end

	// synchronous reset, high for the first four cycles
	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

//--- test/div_unit_chk.sv
// checks the top-level strobe timing only, not the arithmetic; accept is taken from inside the top
module div_unit_chk (
	input logic clock,
	input logic reset,
	input logic accept,
	input logic stall_req,
	input logic commit_valid
);

	// request in flight and the cycles it has waited so far
	logic pending;
	logic [6:0] wait_cycles;

	always_ff @(posedge clock) begin
		if (reset) begin
			pending <= 1'b0;
			wait_cycles <= '0;
		end else if (accept) begin
			// a new accept may share its edge with the previous commit
			pending <= 1'b1;
			wait_cycles <= '0;
		end else if (commit_valid) begin
			pending <= 1'b0;
		end else if (pending) begin
			wait_cycles <= wait_cycles + 7'd1;
		end
	end

	commit_single: assert property (@(posedge clock) disable iff (reset)
		commit_valid |=> !commit_valid)
		else $error("commit_valid stayed high for two cycles");

	stall_after_reset: assert property (@(posedge clock) reset |=> !stall_req)
		else $error("stall_req high right after reset");

	stall_in_commit: assert property (@(posedge clock) disable iff (reset)
		commit_valid |-> !stall_req)
		else $error("stall_req high in a commit cycle");

	// 64 steps plus FIX plus the commit cycle
	commit_in_time: assert property (@(posedge clock) disable iff (reset)
		pending |-> (wait_cycles < 7'd66))
		else $error("no commit within 66 cycles of an accept");

endmodule

//--- test/div_unit_tb.sv
// reads test/div_trace.txt relative to the working directory, so run it from the project root
`include "div_cfg.svh"

module div_unit_tb import div_pkg::*; ();

	logic clock;
	logic reset;

	logic issue_valid;
	div_op_t issue_op;
	logic issue_word;
	reg_addr_t issue_rd;
	xlen_t rs1_data;
	xlen_t rs2_data;
	logic stall_req;
	logic commit_valid;
	reg_addr_t commit_rd;
	xlen_t commit_data;

	// one entry per trace line
	logic [8*24-1:0] names[$];
	logic [1:0] ops[$];
	logic words[$];
	reg_addr_t rd_tags[$];
	xlen_t operand_a[$];
	xlen_t operand_b[$];
	xlen_t exp_data[$];

	int num_tests;
	int cycle;
	int errors;
	int checks;
	int commits_seen;
	int accept_cycles[$];
	logic trace_ready;
	xlen_t last_data;
	reg_addr_t last_rd;

	clock_gen u_clock_gen (
		.clock (clock),
		.reset (reset)
	);

	div_unit_top DUT (
		.clock        (clock),
		.reset        (reset),
		.issue_valid  (issue_valid),
		.issue_op     (issue_op),
		.issue_word   (issue_word),
		.issue_rd     (issue_rd),
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.stall_req    (stall_req),
		.commit_valid (commit_valid),
		.commit_rd    (commit_rd),
		.commit_data  (commit_data)
	);

	bind div_unit_top div_unit_chk u_chk (
		.clock        (clock),
		.reset        (reset),
		.accept       (accept),
		.stall_req    (stall_req),
		.commit_valid (commit_valid)
	);

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	task automatic load_trace();
		int fd;
		int fields;
		int op_v;
		int word_v;
		int rd_v;
		string line;
		logic [8*24-1:0] name_v;
		xlen_t a_v;
		xlen_t b_v;
		xlen_t e_v;
		fd = $fopen("test/div_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open test/div_trace.txt");
			errors = errors + 1;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) != 0) begin
					// comment and blank lines never scan to seven fields
					fields = $sscanf(line, "%s %d %d %d %h %h %h",
						name_v, op_v, word_v, rd_v, a_v, b_v, e_v);
					if (fields == 7) begin
						names.push_back(name_v);
						ops.push_back(op_v[1:0]);
						words.push_back(word_v != 0);
						rd_tags.push_back(reg_addr_t'(rd_v));
						operand_a.push_back(a_v);
						operand_b.push_back(b_v);
						exp_data.push_back(e_v);
					end
				end
			end
			$fclose(fd);
			if (names.size() == 0) begin
				$display("trace file holds no requests");
				errors = errors + 1;
			end
		end
		num_tests = names.size();
	endtask

	// zero divisor or most negative over minus one skip the shift-subtract steps
	function automatic int expected_latency(input int idx);
		logic is_signed;
		logic zero_div;
		logic min_div;
		xlen_t a;
		xlen_t b;
		a = operand_a[idx];
		b = operand_b[idx];
		is_signed = (ops[idx] == 2'd0) || (ops[idx] == 2'd2);
		if (words[idx]) begin
			zero_div = (b[31:0] == 32'h0);
			min_div = is_signed && (a[31:0] == 32'h8000_0000) && (b[31:0] == 32'hffff_ffff);
		end else begin
			zero_div = (b == 64'h0);
			min_div = is_signed && (a == 64'h8000_0000_0000_0000) && (b == '1);
		end
		if (zero_div || min_div) begin
			expected_latency = 2;
		end else if (words[idx]) begin
			expected_latency = `DIV_WORD_LEN + 2;
		end else begin
			expected_latency = `DIV_XLEN + 2;
		end
	endfunction

	task automatic present_request(input int idx);
		issue_valid <= 1'b1;
		issue_op <= div_op_t'(ops[idx]);
		issue_word <= words[idx];
		issue_rd <= rd_tags[idx];
		rs1_data <= operand_a[idx];
		rs2_data <= operand_b[idx];
	endtask

	// returns on the first edge that sees stall_req low
	task automatic wait_until_free();
		do begin
			@(posedge clock);
		end while (stall_req);
	endtask

	task automatic check_commit();
		int idx;
		int delay;
		idx = commits_seen;
		if (idx >= num_tests) begin
			$display("extra commit with rd %0d after all requests were answered", commit_rd);
			errors = errors + 1;
		end else if (accept_cycles.size() == 0) begin
			$display("commit with rd %0d arrived without an accepted request", commit_rd);
			errors = errors + 1;
		end else begin
			delay = cycle - accept_cycles.pop_front();
			checks = checks + 3;
			if (commit_data !== exp_data[idx]) begin
				$display("FAILED %0s data expected %h actual %h",
					names[idx], exp_data[idx], commit_data);
				errors = errors + 1;
			end
			if (commit_rd !== rd_tags[idx]) begin
				$display("FAILED %0s rd expected %0d actual %0d",
					names[idx], rd_tags[idx], commit_rd);
				errors = errors + 1;
			end
			if (delay != expected_latency(idx)) begin
				$display("FAILED %0s latency expected %0d actual %0d",
					names[idx], expected_latency(idx), delay);
				errors = errors + 1;
			end
			commits_seen = commits_seen + 1;
			last_data = commit_data;
			last_rd = commit_rd;
		end
	endtask

	// result and tag must stay put between commits
	task automatic check_hold();
		checks = checks + 1;
		if ((commit_data !== last_data) || (commit_rd !== last_rd)) begin
			$display("FAILED %0s hold expected %0d:%h actual %0d:%h",
				names[commits_seen-1], last_rd, last_data, commit_rd, commit_data);
			errors = errors + 1;
		end
	endtask

	task automatic print_counts();
		$display("requests %0d, commits %0d, checks %0d, errors %0d",
			num_tests, commits_seen, checks, errors);
	endtask

	always @(posedge clock) begin
		if (!reset) begin
			if (commit_valid) begin
				check_commit();
			end else if (commits_seen > 0) begin
				check_hold();
			end
		end
	end

	initial begin
		int i;
		int gap;
		issue_valid = 1'b0;
		issue_op = DIV;
		issue_word = 1'b0;
		issue_rd = '0;
		rs1_data = '0;
		rs2_data = '0;
		cycle = 0;
		errors = 0;
		checks = 0;
		commits_seen = 0;
		trace_ready = 1'b0;
		void'($urandom(32'he66f0815));
		load_trace();
		trace_ready = 1'b1;
		wait (!reset);
		@(posedge clock);
		checks = checks + 1;
		// stall, valid, rd and data all zero
		if (stall_req || commit_valid || (commit_data !== '0) || (commit_rd !== '0)) begin
			$display("FAILED reset_idle expected 0 0 0 %h actual %b %b %0d %h",
				xlen_t'(0), stall_req, commit_valid, commit_rd, commit_data);
			errors = errors + 1;
		end
		for (i = 0; i < num_tests; i = i + 1) begin
			// gap 0 puts the request up while the previous one still runs
			gap = $urandom_range(3, 0);
			if (gap != 0) begin
				issue_valid <= 1'b0;
				wait_until_free();
				repeat (gap) @(posedge clock);
			end
			present_request(i);
			wait_until_free();
			accept_cycles.push_back(cycle);
		end
		issue_valid <= 1'b0;
		wait (commits_seen == num_tests);
		repeat (4) @(posedge clock);
		print_counts();
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// longest request is 66 cycles plus up to 4 idle ones
	initial begin
		wait (trace_ready);
		while (cycle < num_tests * 70 + 100) begin
			@(posedge clock);
		end
		$display("timeout after %0d cycles, %0d of %0d commits seen",
			cycle, commits_seen, num_tests);
		errors = errors + 1;
		print_counts();
		$display("Something failed");
		$finish;
	end

endmodule

//--- test/div_trace.txt
# name op word rd rs1 rs2 expected; op word rd in decimal, operands and result in hex
# op: 0 div, 1 divu, 2 rem, 3 remu; word 1 selects the 32-bit form
divu_basic 1 0 1 0000000000000064 0000000000000007 000000000000000e
remu_basic 3 0 2 0000000000000064 0000000000000007 0000000000000002
divu_all_ones 1 0 3 ffffffffffffffff 0000000000000002 7fffffffffffffff
remu_all_ones 3 0 4 ffffffffffffffff 0000000000000002 0000000000000001
divu_shift 1 0 5 123456789abcdef0 0000000000000010 0123456789abcdef
remu_low_byte 3 0 6 123456789abcdef0 0000000000000100 00000000000000f0
divu_small_big 1 0 7 0000000000000005 ffffffffffffffff 0000000000000000
remu_small_big 3 0 8 0000000000000005 ffffffffffffffff 0000000000000005
divu_top_bit 1 0 9 8000000000000000 0000000000000003 2aaaaaaaaaaaaaaa
remu_top_bit 3 0 10 8000000000000000 0000000000000003 0000000000000002
divu_same 1 0 11 fedcba9876543210 fedcba9876543210 0000000000000001
remu_same 3 0 12 fedcba9876543210 fedcba9876543210 0000000000000000
div_neg_pos 0 0 13 fffffffffffffff9 0000000000000002 fffffffffffffffd
rem_neg_pos 2 0 14 fffffffffffffff9 0000000000000002 ffffffffffffffff
div_pos_neg 0 0 15 0000000000000007 fffffffffffffffe fffffffffffffffd
rem_pos_neg 2 0 16 0000000000000007 fffffffffffffffe 0000000000000001
div_neg_neg 0 0 17 fffffffffffffff9 fffffffffffffffe 0000000000000003
rem_neg_neg 2 0 18 fffffffffffffff9 fffffffffffffffe ffffffffffffffff
div_hundred 0 0 19 ffffffffffffff9c 0000000000000007 fffffffffffffff2
rem_hundred 2 0 20 ffffffffffffff9c 0000000000000007 fffffffffffffffe
div_by_minus_one 0 0 21 fffffffffffffc18 ffffffffffffffff 00000000000003e8
rem_thousand 2 0 22 00000000000003e8 ffffffffffffffe1 0000000000000008
divw_junk_upper 0 1 23 12345678fffffff9 abcdef0000000002 fffffffffffffffd
remw_junk_upper 2 1 24 12345678fffffff9 abcdef0000000002 ffffffffffffffff
divuw_half 1 1 25 deadbeef80000000 0000000100000002 0000000040000000
divuw_sign_ext 1 1 26 00000000ffffffff 0000000000000001 ffffffffffffffff
remuw_sign_ext 3 1 27 55555555fffffffe 00000000ffffffff fffffffffffffffe
remuw_small 3 1 28 0000000000000064 ffffffff00000007 0000000000000002
divuw_max 1 1 29 ffffffffffffffff 0000000000000010 000000000fffffff
remw_neg 2 1 30 00000000ffffff9c 0000000000000007 fffffffffffffffe
divw_neg_neg 0 1 31 00000000ffffff9c 00000000fffffff9 000000000000000e
div_zero 0 0 1 0000000000001234 0000000000000000 ffffffffffffffff
rem_zero 2 0 2 fffffffffffffff9 0000000000000000 fffffffffffffff9
divu_zero 1 0 3 000000000000002a 0000000000000000 ffffffffffffffff
remu_zero 3 0 4 123456789abcdef0 0000000000000000 123456789abcdef0
divw_zero 0 1 5 0000000012345678 ffffffff00000000 ffffffffffffffff
remuw_zero 3 1 6 0000000080000001 1111111100000000 ffffffff80000001
div_overflow 0 0 7 8000000000000000 ffffffffffffffff 8000000000000000
rem_overflow 2 0 8 8000000000000000 ffffffffffffffff 0000000000000000
divw_overflow 0 1 9 0000000080000000 00000000ffffffff ffffffff80000000
remw_overflow 2 1 10 0000000080000000 00000000ffffffff 0000000000000000
divu_no_overflow 1 0 0 8000000000000000 ffffffffffffffff 0000000000000000

//--- src.f
+incdir+logic
logic/div_pkg.sv
logic/iteration_counter.sv
logic/div_control.sv
logic/div_datapath.sv
logic/div_unit_top.sv
test/clock_gen.sv
test/div_unit_chk.sv
test/div_unit_tb.sv

//--- Makefile
# Verilator build and run of the divider testbench, called from the project root

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module div_unit_tb \
		-f src.f -o div_unit_sim

run: compile
	./obj_dir/div_unit_sim > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Something failed" sim.log; then \
		echo "result: FAIL"; exit 1; \
	elif grep -q "Everything OK" sim.log; then \
		echo "result: PASS"; \
	else \
		echo "result: FAIL, run ended without a closing message"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
